// File: hw/xbar_pkg.sv
// ------------------------------------------------
// Crossbar package with widths, port counts,
// the fixed address map and shared index types
// ------------------------------------------------
package xbar_pkg;

  localparam int N_INIT    = 2;
  localparam int N_TGT     = 2;
  localparam int ADDR_W    = 32;
  localparam int DATA_W    = 32;
  localparam int STRB_W    = DATA_W / 8;
  localparam int MAX_TRANS = 4;  // Outstanding per demux and per mux
  localparam int CNT_W     = $clog2(MAX_TRANS + 1);
  localparam int Q_PTR_W   = (MAX_TRANS > 1) ? $clog2(MAX_TRANS) : 1;

  // One extra index for the decode-error responder
  localparam int TGT_IDX_W  = $clog2(N_TGT + 1);
  localparam int INIT_IDX_W = (N_INIT > 1) ? $clog2(N_INIT) : 1;

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [STRB_W-1:0]     strb_t;
  typedef logic [TGT_IDX_W-1:0]  tgt_idx_t;
  typedef logic [INIT_IDX_W-1:0] init_idx_t;

  // Address rules, both bounds inclusive
  localparam addr_t TGT0_BASE = 32'h0000_0000;
  localparam addr_t TGT0_END  = 32'h0000_0FFF;
  localparam addr_t TGT1_BASE = 32'h0000_1000;
  localparam addr_t TGT1_END  = 32'h0000_1FFF;

  // Rule table indexed by target
  localparam addr_t [N_TGT-1:0] TGT_BASE = {TGT1_BASE, TGT0_BASE};
  localparam addr_t [N_TGT-1:0] TGT_END  = {TGT1_END, TGT0_END};

endpackage

// File: hw/xbar_addr_decode.sv
// ------------------------------------------------
// Address decoder, maps an address onto a target
// index or flags a decode error
// ------------------------------------------------
`timescale 1ns/1ps

module xbar_addr_decode import xbar_pkg::*; (
  input  addr_t    addr_i,
  output tgt_idx_t idx_o,
  output logic     dec_err_o
);

  // Default is the error responder at index N_TGT
  always_comb begin
    idx_o     = tgt_idx_t'(N_TGT);
    dec_err_o = 1'b1;
    // Walk downwards so the lowest matching rule wins
    for (int j = N_TGT - 1; j >= 0; j--) begin
      if ((addr_i >= TGT_BASE[j]) && (addr_i <= TGT_END[j])) begin
        idx_o     = tgt_idx_t'(j);
        dec_err_o = 1'b0;
      end
    end
  end

endmodule

// File: hw/xbar_demux.sv
// ------------------------------------------------
// Per-initiator request router, tracks outstanding
// requests and answers unmapped addresses itself
// ------------------------------------------------
`timescale 1ns/1ps

module xbar_demux import xbar_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 slv_req_valid_i,
  output logic                 slv_req_ready_o,
  input  logic                 slv_req_write_i,
  input  addr_t                slv_req_addr_i,
  input  data_t                slv_req_wdata_i,
  input  strb_t                slv_req_strb_i,
  output logic                 slv_rsp_valid_o,
  input  logic                 slv_rsp_ready_i,
  output data_t                slv_rsp_rdata_o,
  output logic                 slv_rsp_err_o,
  output logic  [N_TGT-1:0]    mst_req_valid_o,
  input  logic  [N_TGT-1:0]    mst_req_ready_i,
  output logic                 mst_req_write_o,
  output addr_t                mst_req_addr_o,
  output data_t                mst_req_wdata_o,
  output strb_t                mst_req_strb_o,
  input  logic  [N_TGT-1:0]    mst_rsp_valid_i,
  output logic  [N_TGT-1:0]    mst_rsp_ready_o,
  input  data_t [N_TGT-1:0]    mst_rsp_rdata_i,
  input  logic  [N_TGT-1:0]    mst_rsp_err_i
);

  tgt_idx_t         sel;
  logic             dec_err;
  tgt_idx_t         cur_tgt_q;
  logic [CNT_W-1:0] cnt_q;
  logic             err_valid_q;
  logic             stall;
  logic             req_fire;
  logic             rsp_fire;
  logic             err_fire;

  xbar_addr_decode i_decode (
    .addr_i    (slv_req_addr_i),
    .idx_o     (sel),
    .dec_err_o (dec_err)
  );

  // Same payload goes to every target, only valid is steered
  assign mst_req_write_o = slv_req_write_i;
  assign mst_req_addr_o  = slv_req_addr_i;
  assign mst_req_wdata_o = slv_req_wdata_i;
  assign mst_req_strb_o  = slv_req_strb_i;

  // Switching targets waits for the old one to drain, keeps responses in order
  assign stall = (cnt_q == CNT_W'(MAX_TRANS)) ||
                 ((cnt_q != '0) && (sel != cur_tgt_q));

  always_comb begin
    mst_req_valid_o = '0;
    slv_req_ready_o = 1'b0;
    if (slv_req_valid_i && !stall) begin
      if (dec_err) begin
        slv_req_ready_o = !err_valid_q;  // Responder holds one entry
      end else begin
        for (int j = 0; j < N_TGT; j++) begin
          if (sel == tgt_idx_t'(j)) begin
            mst_req_valid_o[j] = 1'b1;
            slv_req_ready_o    = mst_req_ready_i[j];
          end
        end
      end
    end
  end

  // Responses come only from the current target
  always_comb begin
    slv_rsp_valid_o = 1'b0;
    slv_rsp_rdata_o = '0;
    slv_rsp_err_o   = 1'b0;
    mst_rsp_ready_o = '0;
    if (cur_tgt_q == tgt_idx_t'(N_TGT)) begin
      slv_rsp_valid_o = err_valid_q;
      slv_rsp_err_o   = 1'b1;
    end
    for (int j = 0; j < N_TGT; j++) begin
      if (cur_tgt_q == tgt_idx_t'(j)) begin
        slv_rsp_valid_o    = mst_rsp_valid_i[j];
        slv_rsp_rdata_o    = mst_rsp_rdata_i[j];
        slv_rsp_err_o      = mst_rsp_err_i[j];
        mst_rsp_ready_o[j] = slv_rsp_ready_i;
      end
    end
  end

  assign req_fire = slv_req_valid_i && slv_req_ready_o;
  assign rsp_fire = slv_rsp_valid_o && slv_rsp_ready_i;
  assign err_fire = rsp_fire && (cur_tgt_q == tgt_idx_t'(N_TGT));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q       <= '0;
      cur_tgt_q   <= '0;
      err_valid_q <= 1'b0;
    end else begin
      if (req_fire && !rsp_fire) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (!req_fire && rsp_fire) begin
        cnt_q <= cnt_q - 1'b1;
      end
      if (req_fire) cur_tgt_q <= sel;
      if (err_fire) err_valid_q <= 1'b0;
      if (req_fire && dec_err) err_valid_q <= 1'b1;  // Answer next cycle
    end
  end

  a_cnt_bound : assert property (@(posedge clk_i) disable iff (rst_i)
    cnt_q <= CNT_W'(MAX_TRANS));

  // Initiator must hold its request until accepted
  a_req_stable : assert property (@(posedge clk_i) disable iff (rst_i)
    (slv_req_valid_i && !slv_req_ready_o) |=> slv_req_valid_i &&
      $stable({slv_req_write_i, slv_req_addr_i, slv_req_wdata_i, slv_req_strb_i}));

endmodule

// File: hw/xbar_spill_reg.sv
// ------------------------------------------------
// One-entry request buffer between demux and mux,
// refills in the cycle it drains
// ------------------------------------------------
`timescale 1ns/1ps

module xbar_spill_reg import xbar_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  in_valid_i,
  output logic  in_ready_o,
  input  logic  in_write_i,
  input  addr_t in_addr_i,
  input  data_t in_wdata_i,
  input  strb_t in_strb_i,
  output logic  out_valid_o,
  input  logic  out_ready_i,
  output logic  out_write_o,
  output addr_t out_addr_o,
  output data_t out_wdata_o,
  output strb_t out_strb_o
);

  logic full_q;
  logic load;

  assign in_ready_o  = !full_q || out_ready_i;  // Free or draining now
  assign load        = in_valid_i && in_ready_o;
  assign out_valid_o = full_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end else if (out_ready_i) begin
      full_q <= 1'b0;
    end
  end

  // Payload entry
  always_ff @(posedge clk_i) begin
    if (load) begin
      out_write_o <= in_write_i;
      out_addr_o  <= in_addr_i;
      out_wdata_o <= in_wdata_i;
      out_strb_o  <= in_strb_i;
    end
  end

  // Demux side holds its offer until the buffer takes it
  a_in_stable : assert property (@(posedge clk_i) disable iff (rst_i)
    (in_valid_i && !in_ready_o) |=> in_valid_i &&
      $stable({in_write_i, in_addr_i, in_wdata_i, in_strb_i}));

endmodule

// File: hw/xbar_mux.sv
// ------------------------------------------------
// Per-target round-robin arbiter, returns responses
// to initiators in grant order
// ------------------------------------------------
`timescale 1ns/1ps

module xbar_mux import xbar_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic  [N_INIT-1:0]    slv_req_valid_i,
  output logic  [N_INIT-1:0]    slv_req_ready_o,
  input  logic  [N_INIT-1:0]    slv_req_write_i,
  input  addr_t [N_INIT-1:0]    slv_req_addr_i,
  input  data_t [N_INIT-1:0]    slv_req_wdata_i,
  input  strb_t [N_INIT-1:0]    slv_req_strb_i,
  output logic  [N_INIT-1:0]    slv_rsp_valid_o,
  input  logic  [N_INIT-1:0]    slv_rsp_ready_i,
  output data_t                 slv_rsp_rdata_o,
  output logic                  slv_rsp_err_o,
  output logic                  mst_req_valid_o,
  input  logic                  mst_req_ready_i,
  output logic                  mst_req_write_o,
  output addr_t                 mst_req_addr_o,
  output data_t                 mst_req_wdata_o,
  output strb_t                 mst_req_strb_o,
  input  logic                  mst_rsp_valid_i,
  output logic                  mst_rsp_ready_o,
  input  data_t                 mst_rsp_rdata_i,
  input  logic                  mst_rsp_err_i
);

  init_idx_t          rr_ptr_q;
  logic               lock_q;
  init_idx_t          lock_idx_q;
  logic               arb_valid;
  init_idx_t          arb_idx;
  init_idx_t          gnt_idx;
  logic               req_fire;
  logic               rsp_fire;
  init_idx_t          order_q [MAX_TRANS];
  logic [Q_PTR_W-1:0] wr_ptr_q;
  logic [Q_PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0]   q_cnt_q;
  init_idx_t          head;

  // First valid initiator at or after the pointer
  always_comb begin
    int c;
    arb_valid = 1'b0;
    arb_idx   = rr_ptr_q;
    for (int k = N_INIT - 1; k >= 0; k--) begin
      c = (int'(rr_ptr_q) + k) % N_INIT;
      if (slv_req_valid_i[c]) begin
        arb_valid = 1'b1;
        arb_idx   = init_idx_t'(c);
      end
    end
  end

  assign gnt_idx         = lock_q ? lock_idx_q : arb_idx;
  assign mst_req_valid_o = (lock_q || arb_valid) && (q_cnt_q != CNT_W'(MAX_TRANS));
  assign mst_req_write_o = slv_req_write_i[gnt_idx];
  assign mst_req_addr_o  = slv_req_addr_i[gnt_idx];
  assign mst_req_wdata_o = slv_req_wdata_i[gnt_idx];
  assign mst_req_strb_o  = slv_req_strb_i[gnt_idx];
  assign req_fire        = mst_req_valid_o && mst_req_ready_i;

  always_comb begin
    slv_req_ready_o          = '0;
    slv_req_ready_o[gnt_idx] = req_fire;
  end

  // Response goes to the oldest granted initiator
  assign head            = order_q[rd_ptr_q];
  assign mst_rsp_ready_o = (q_cnt_q != '0) && slv_rsp_ready_i[head];  // Low while queue empty
  assign rsp_fire        = mst_rsp_valid_i && mst_rsp_ready_o;
  assign slv_rsp_rdata_o = mst_rsp_rdata_i;
  assign slv_rsp_err_o   = mst_rsp_err_i;

  always_comb begin
    slv_rsp_valid_o       = '0;
    slv_rsp_valid_o[head] = mst_rsp_valid_i;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_ptr_q   <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      q_cnt_q    <= '0;
    end else begin
      if (req_fire) begin
        lock_q   <= 1'b0;
        rr_ptr_q <= (gnt_idx == init_idx_t'(N_INIT - 1)) ? '0 : gnt_idx + 1'b1;
        wr_ptr_q <= (wr_ptr_q == Q_PTR_W'(MAX_TRANS - 1)) ? '0 : wr_ptr_q + 1'b1;
      end else if (mst_req_valid_o) begin
        lock_q     <= 1'b1;  // Hold grant until the target takes it
        lock_idx_q <= gnt_idx;
      end
      if (rsp_fire) begin
        rd_ptr_q <= (rd_ptr_q == Q_PTR_W'(MAX_TRANS - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (req_fire && !rsp_fire) q_cnt_q <= q_cnt_q + 1'b1;
      if (!req_fire && rsp_fire) q_cnt_q <= q_cnt_q - 1'b1;
    end
  end

  // Order queue storage
  always_ff @(posedge clk_i) begin
    if (req_fire) order_q[wr_ptr_q] <= gnt_idx;
  end

  a_rsp_expected : assert property (@(posedge clk_i) disable iff (rst_i)
    mst_rsp_valid_i |-> (q_cnt_q != '0));

  // Stalled grant keeps its initiator and the payload seen by the target
  a_grant_held : assert property (@(posedge clk_i) disable iff (rst_i)
    (mst_req_valid_o && !mst_req_ready_i) |=>
      mst_req_valid_o && (gnt_idx == $past(gnt_idx)) &&
      $stable({mst_req_write_o, mst_req_addr_o, mst_req_wdata_o, mst_req_strb_o}));

endmodule

// File: hw/lite_xbar.sv
// ------------------------------------------------
// Register access crossbar, demux per initiator,
// spill buffer per crossing and mux per target
// ------------------------------------------------
`timescale 1ns/1ps

module lite_xbar import xbar_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic  [N_INIT-1:0]  init_req_valid_i,
  output logic  [N_INIT-1:0]  init_req_ready_o,
  input  logic  [N_INIT-1:0]  init_req_write_i,
  input  addr_t [N_INIT-1:0]  init_req_addr_i,
  input  data_t [N_INIT-1:0]  init_req_wdata_i,
  input  strb_t [N_INIT-1:0]  init_req_strb_i,
  output logic  [N_INIT-1:0]  init_rsp_valid_o,
  input  logic  [N_INIT-1:0]  init_rsp_ready_i,
  output data_t [N_INIT-1:0]  init_rsp_rdata_o,
  output logic  [N_INIT-1:0]  init_rsp_err_o,
  output logic  [N_TGT-1:0]   tgt_req_valid_o,
  input  logic  [N_TGT-1:0]   tgt_req_ready_i,
  output logic  [N_TGT-1:0]   tgt_req_write_o,
  output addr_t [N_TGT-1:0]   tgt_req_addr_o,
  output data_t [N_TGT-1:0]   tgt_req_wdata_o,
  output strb_t [N_TGT-1:0]   tgt_req_strb_o,
  input  logic  [N_TGT-1:0]   tgt_rsp_valid_i,
  output logic  [N_TGT-1:0]   tgt_rsp_ready_o,
  input  data_t [N_TGT-1:0]   tgt_rsp_rdata_i,
  input  logic  [N_TGT-1:0]   tgt_rsp_err_i
);

  // Demux side, indexed [initiator][target]
  logic  [N_INIT-1:0][N_TGT-1:0] dmx_req_valid, dmx_req_ready;
  logic  [N_INIT-1:0][N_TGT-1:0] dmx_rsp_valid, dmx_rsp_ready;
  logic  [N_INIT-1:0]            dmx_req_write;
  addr_t [N_INIT-1:0]            dmx_req_addr;
  data_t [N_INIT-1:0]            dmx_req_wdata;
  strb_t [N_INIT-1:0]            dmx_req_strb;

  // Mux side, indexed [target][initiator]
  logic  [N_TGT-1:0][N_INIT-1:0] mux_req_valid, mux_req_ready, mux_req_write;
  addr_t [N_TGT-1:0][N_INIT-1:0] mux_req_addr;
  data_t [N_TGT-1:0][N_INIT-1:0] mux_req_wdata;
  strb_t [N_TGT-1:0][N_INIT-1:0] mux_req_strb;
  logic  [N_TGT-1:0][N_INIT-1:0] mux_rsp_valid, mux_rsp_ready;
  data_t [N_TGT-1:0]             mux_rsp_rdata;  // Broadcast to all initiators
  logic  [N_TGT-1:0]             mux_rsp_err;

  for (genvar i = 0; i < N_INIT; i++) begin : gen_demux
    xbar_demux i_demux (
      .clk_i, .rst_i,
      .slv_req_valid_i (init_req_valid_i[i]), .slv_req_ready_o (init_req_ready_o[i]),
      .slv_req_write_i (init_req_write_i[i]), .slv_req_addr_i  (init_req_addr_i[i]),
      .slv_req_wdata_i (init_req_wdata_i[i]), .slv_req_strb_i  (init_req_strb_i[i]),
      .slv_rsp_valid_o (init_rsp_valid_o[i]), .slv_rsp_ready_i (init_rsp_ready_i[i]),
      .slv_rsp_rdata_o (init_rsp_rdata_o[i]), .slv_rsp_err_o   (init_rsp_err_o[i]),
      .mst_req_valid_o (dmx_req_valid[i]),    .mst_req_ready_i (dmx_req_ready[i]),
      .mst_req_write_o (dmx_req_write[i]),    .mst_req_addr_o  (dmx_req_addr[i]),
      .mst_req_wdata_o (dmx_req_wdata[i]),    .mst_req_strb_o  (dmx_req_strb[i]),
      .mst_rsp_valid_i (dmx_rsp_valid[i]),    .mst_rsp_ready_o (dmx_rsp_ready[i]),
      .mst_rsp_rdata_i (mux_rsp_rdata),       .mst_rsp_err_i   (mux_rsp_err)
    );
  end

  for (genvar i = 0; i < N_INIT; i++) begin : gen_cross_i
    for (genvar j = 0; j < N_TGT; j++) begin : gen_cross_j
      xbar_spill_reg i_spill (
        .clk_i, .rst_i,
        .in_valid_i  (dmx_req_valid[i][j]), .in_ready_o  (dmx_req_ready[i][j]),
        .in_write_i  (dmx_req_write[i]),    .in_addr_i   (dmx_req_addr[i]),
        .in_wdata_i  (dmx_req_wdata[i]),    .in_strb_i   (dmx_req_strb[i]),
        .out_valid_o (mux_req_valid[j][i]), .out_ready_i (mux_req_ready[j][i]),
        .out_write_o (mux_req_write[j][i]), .out_addr_o  (mux_req_addr[j][i]),
        .out_wdata_o (mux_req_wdata[j][i]), .out_strb_o  (mux_req_strb[j][i])
      );
      assign dmx_rsp_valid[i][j] = mux_rsp_valid[j][i];
      assign mux_rsp_ready[j][i] = dmx_rsp_ready[i][j];
    end
  end

  for (genvar j = 0; j < N_TGT; j++) begin : gen_mux
    xbar_mux i_mux (
      .clk_i, .rst_i,
      .slv_req_valid_i (mux_req_valid[j]),   .slv_req_ready_o (mux_req_ready[j]),
      .slv_req_write_i (mux_req_write[j]),   .slv_req_addr_i  (mux_req_addr[j]),
      .slv_req_wdata_i (mux_req_wdata[j]),   .slv_req_strb_i  (mux_req_strb[j]),
      .slv_rsp_valid_o (mux_rsp_valid[j]),   .slv_rsp_ready_i (mux_rsp_ready[j]),
      .slv_rsp_rdata_o (mux_rsp_rdata[j]),   .slv_rsp_err_o   (mux_rsp_err[j]),
      .mst_req_valid_o (tgt_req_valid_o[j]), .mst_req_ready_i (tgt_req_ready_i[j]),
      .mst_req_write_o (tgt_req_write_o[j]), .mst_req_addr_o  (tgt_req_addr_o[j]),
      .mst_req_wdata_o (tgt_req_wdata_o[j]), .mst_req_strb_o  (tgt_req_strb_o[j]),
      .mst_rsp_valid_i (tgt_rsp_valid_i[j]), .mst_rsp_ready_o (tgt_rsp_ready_o[j]),
      .mst_rsp_rdata_i (tgt_rsp_rdata_i[j]), .mst_rsp_err_i   (tgt_rsp_err_i[j])
    );
  end

endmodule

// File: verif/tb_target_mem.sv
// ------------------------------------------------
// Target model with a word memory, gated ready
// and a response latency set by the testbench
// ------------------------------------------------
`timescale 1ns/1ps

module tb_target_mem import xbar_pkg::*; #(
  parameter addr_t BASE = '0
) (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       req_valid_i,
  output logic       req_ready_o,
  input  logic       req_write_i,
  input  addr_t      req_addr_i,
  input  data_t      req_wdata_i,
  input  strb_t      req_strb_i,
  output logic       rsp_valid_o,
  input  logic       rsp_ready_i,
  output data_t      rsp_rdata_o,
  output logic       rsp_err_o,
  input  logic       ready_en_i,  // Random gate from the testbench
  input  logic [2:0] lat_i
);

  localparam int WORDS = 1024;

  data_t            mem [WORDS];
  logic [WORDS-1:0] written_q;  // Unwritten words read as the fill pattern
  logic             busy_q;
  logic [2:0]       wait_q;
  addr_t            offs;
  logic [9:0]       widx;
  addr_t            waddr;

  // Pattern over the whole word address
  function automatic data_t fill_word(input addr_t a);
    return (a * 32'h9E37_79B9) ^ 32'h3C6E_F372;
  endfunction

  assign offs        = req_addr_i - BASE;  // Offset inside the target window
  assign widx        = offs[11:2];
  assign waddr       = {req_addr_i[ADDR_W-1:2], 2'b00};
  assign req_ready_o = !busy_q && ready_en_i;  // One request at a time
  assign rsp_err_o   = 1'b0;

  always @(posedge clk_i) begin : seq
    data_t cur;
    cur = written_q[widx] ? mem[widx] : fill_word(waddr);
    if (rst_i) begin
      busy_q      <= 1'b0;
      wait_q      <= '0;
      rsp_valid_o <= 1'b0;
      rsp_rdata_o <= '0;
      written_q   <= '0;
    end else if (!busy_q) begin
      if (req_valid_i && req_ready_o) begin
        busy_q <= 1'b1;
        wait_q <= lat_i;
        if (req_write_i) begin
          for (int b = 0; b < STRB_W; b++) begin
            if (req_strb_i[b]) cur[8*b +: 8] = req_wdata_i[8*b +: 8];
          end
          mem[widx]       <= cur;
          written_q[widx] <= 1'b1;
          rsp_rdata_o     <= '0;
        end else begin
          rsp_rdata_o <= cur;
        end
      end
    end else if (!rsp_valid_o) begin
      if (wait_q == 3'd0) rsp_valid_o <= 1'b1;
      else wait_q <= wait_q - 3'd1;
    end else if (rsp_ready_i) begin
      rsp_valid_o <= 1'b0;
      busy_q      <= 1'b0;
    end
  end

endmodule

// File: verif/tb_lite_xbar.sv
// ------------------------------------------------
// Testbench for the crossbar, random traffic from
// two initiators checked against a shadow memory
// ------------------------------------------------
`timescale 1ns/1ps

module tb_lite_xbar import xbar_pkg::*; ();

  localparam int N_DIR     = 11;  // Directed requests per initiator
  localparam int N_RAND    = 60;
  localparam int TOTAL_TXN = N_INIT * (N_DIR + N_RAND);

  logic clk_i;
  logic rst_i;
  logic  [N_INIT-1:0]       init_req_valid, init_req_ready, init_req_write;
  addr_t [N_INIT-1:0]       init_req_addr;
  data_t [N_INIT-1:0]       init_req_wdata;
  strb_t [N_INIT-1:0]       init_req_strb;
  logic  [N_INIT-1:0]       init_rsp_valid, init_rsp_ready, init_rsp_err;
  data_t [N_INIT-1:0]       init_rsp_rdata;
  logic  [N_TGT-1:0]        tgt_req_valid, tgt_req_ready, tgt_req_write;
  addr_t [N_TGT-1:0]        tgt_req_addr;
  data_t [N_TGT-1:0]        tgt_req_wdata;
  strb_t [N_TGT-1:0]        tgt_req_strb;
  logic  [N_TGT-1:0]        tgt_rsp_valid, tgt_rsp_ready, tgt_rsp_err;
  data_t [N_TGT-1:0]        tgt_rsp_rdata;
  logic  [N_TGT-1:0]        tgt_ready_en;
  logic  [N_TGT-1:0][2:0]   tgt_lat;

  logic [15:0] lfsr = 16'd33311;
  data_t       shadow [addr_t];
  data_t       exp_data_q [N_INIT][$];
  logic        exp_err_q [N_INIT][$];
  int          quiet_cycles = 0;

  lite_xbar lite_xbar_i (
    .clk_i, .rst_i,
    .init_req_valid_i (init_req_valid), .init_req_ready_o (init_req_ready),
    .init_req_write_i (init_req_write), .init_req_addr_i  (init_req_addr),
    .init_req_wdata_i (init_req_wdata), .init_req_strb_i  (init_req_strb),
    .init_rsp_valid_o (init_rsp_valid), .init_rsp_ready_i (init_rsp_ready),
    .init_rsp_rdata_o (init_rsp_rdata), .init_rsp_err_o   (init_rsp_err),
    .tgt_req_valid_o  (tgt_req_valid),  .tgt_req_ready_i  (tgt_req_ready),
    .tgt_req_write_o  (tgt_req_write),  .tgt_req_addr_o   (tgt_req_addr),
    .tgt_req_wdata_o  (tgt_req_wdata),  .tgt_req_strb_o   (tgt_req_strb),
    .tgt_rsp_valid_i  (tgt_rsp_valid),  .tgt_rsp_ready_o  (tgt_rsp_ready),
    .tgt_rsp_rdata_i  (tgt_rsp_rdata),  .tgt_rsp_err_i    (tgt_rsp_err)
  );

  for (genvar j = 0; j < N_TGT; j++) begin : gen_tgt
    tb_target_mem #(.BASE(j == 0 ? TGT0_BASE : TGT1_BASE)) tgt_mem_i (
      .clk_i, .rst_i,
      .req_valid_i (tgt_req_valid[j]), .req_ready_o (tgt_req_ready[j]),
      .req_write_i (tgt_req_write[j]), .req_addr_i  (tgt_req_addr[j]),
      .req_wdata_i (tgt_req_wdata[j]), .req_strb_i  (tgt_req_strb[j]),
      .rsp_valid_o (tgt_rsp_valid[j]), .rsp_ready_i (tgt_rsp_ready[j]),
      .rsp_rdata_o (tgt_rsp_rdata[j]), .rsp_err_o   (tgt_rsp_err[j]),
      .ready_en_i  (tgt_ready_en[j]),  .lat_i       (tgt_lat[j])
    );
  end

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Galois LFSR, one step per bit
  function automatic logic next_bit();
    logic b;
    b    = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) lfsr = lfsr ^ 16'hB400;
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) v = {v[30:0], next_bit()};
    return v;
  endfunction

  function automatic data_t fill_word(input addr_t a);
    return (a * 32'h9E37_79B9) ^ 32'h3C6E_F372;
  endfunction

  function automatic logic in_rule(input int j, input addr_t a);
    if (j == 0) return (a >= TGT0_BASE) && (a <= TGT0_END);
    return (a >= TGT1_BASE) && (a <= TGT1_END);
  endfunction

  // Expected response of one request, updates the shadow on writes
  function automatic data_t ref_access(input logic write, input addr_t addr,
                                       input data_t wdata, input strb_t strb,
                                       output logic err);
    data_t cur;
    err = !(in_rule(0, addr) || in_rule(1, addr));
    if (err) return '0;
    cur = shadow.exists(addr) ? shadow[addr] : fill_word(addr);
    if (!write) return cur;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) cur[8*b +: 8] = wdata[8*b +: 8];
    end
    shadow[addr] = cur;
    return '0;
  endfunction

  // Own half of each target per initiator
  function automatic addr_t make_addr(input int i, input int j, input int word);
    return addr_t'(j * 32'h1000 + i * 32'h800 + word * 4);
  endfunction

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR t=%0t %s expected %b actual %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  // Entered and left 1 ns after a rising edge
  task automatic issue(input int i, input logic write, input addr_t addr,
                       input data_t wdata, input strb_t strb);
    data_t e;
    logic  ee;
    e = ref_access(write, addr, wdata, strb, ee);
    exp_data_q[i].push_back(e);
    exp_err_q[i].push_back(ee);
    init_req_valid[i] = 1'b1;
    init_req_write[i] = write;
    init_req_addr[i]  = addr;
    init_req_wdata[i] = wdata;
    init_req_strb[i]  = strb;
    @(negedge clk_i);
    while (!init_req_ready[i]) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    init_req_valid[i] = 1'b0;
  endtask

  task automatic run_initiator(input int i);
    logic [1:0] kind;
    int         word;
    addr_t      a;
    for (int j = 0; j < N_TGT; j++) begin
      a = make_addr(i, j, 5 + j);
      issue(i, 1'b1, a, rand_bits(32), 4'hF);
      issue(i, 1'b0, a, '0, '0);
      issue(i, 1'b1, a, rand_bits(32), 4'b0101);  // Partial strobe
      issue(i, 1'b0, a, '0, '0);
    end
    issue(i, 1'b1, addr_t'(32'h0000_2000 + i * 16), rand_bits(32), 4'hF);
    issue(i, 1'b0, addr_t'(32'h0000_2000 + i * 16), '0, '0);
    issue(i, 1'b0, 32'hFFFF_FFF0, '0, '0);
    for (int n = 0; n < N_RAND; n++) begin
      kind = 2'(rand_bits(2));
      word = int'(rand_bits(6));
      if (kind < 2'd2) a = make_addr(i, int'(kind), word);
      else a = addr_t'(32'h0000_2000 + word * 4 + (kind == 2'd3 ? 32'h4000_0000 : 0));
      issue(i, next_bit(), a, rand_bits(32), strb_t'(rand_bits(STRB_W)));
      if (next_bit()) begin
        @(posedge clk_i);
        #1;
      end
    end
  endtask

  // Random ready and latency, driven after each edge
  task automatic pressure_loop();
    forever begin
      @(posedge clk_i);
      #1;
      for (int i = 0; i < N_INIT; i++) init_rsp_ready[i] = next_bit() | next_bit();
      for (int j = 0; j < N_TGT; j++) begin
        tgt_ready_en[j] = next_bit() | next_bit();
        tgt_lat[j]      = 3'(rand_bits(3));
      end
    end
  endtask

  // Samples at the falling edge where everything is settled
  task automatic monitor_loop();
    forever begin
      @(negedge clk_i);
      if (rst_i || quiet_cycles < 2) begin
        for (int i = 0; i < N_INIT; i++) check_flag("init_rsp_valid_o", 1'b0, init_rsp_valid[i]);
        for (int j = 0; j < N_TGT; j++) check_flag("tgt_req_valid_o", 1'b0, tgt_req_valid[j]);
      end
      if (!rst_i) quiet_cycles++;
      for (int i = 0; i < N_INIT; i++) begin
        if (init_rsp_valid[i] && init_rsp_ready[i]) begin
          if (exp_data_q[i].size() == 0) begin
            $display("Initiator %0d got a response with no request pending", i);
            abort_run();
          end else begin
            check_data($sformatf("init_rsp_rdata_o[%0d]", i), exp_data_q[i].pop_front(),
                       init_rsp_rdata[i]);
            check_flag($sformatf("init_rsp_err_o[%0d]", i), exp_err_q[i].pop_front(),
                       init_rsp_err[i]);
          end
        end
      end
      for (int j = 0; j < N_TGT; j++) begin
        if (tgt_req_valid[j] && tgt_req_ready[j] && !in_rule(j, tgt_req_addr[j])) begin
          $display("Target %0d received address %h outside its rule", j, tgt_req_addr[j]);
          abort_run();
        end
      end
    end
  endtask

  function automatic int pending();
    return exp_data_q[0].size() + exp_data_q[1].size();
  endfunction

  initial begin
    rst_i          = 1'b1;
    init_req_valid = '0;
    init_req_write = '0;
    init_req_addr  = '0;
    init_req_wdata = '0;
    init_req_strb  = '0;
    init_rsp_ready = '0;
    tgt_ready_en   = '0;
    tgt_lat        = '0;
    fork
      monitor_loop();
      pressure_loop();
      begin
        repeat (4) @(posedge clk_i);
        #1 rst_i = 1'b0;
        repeat (3) @(posedge clk_i);
        #1;
        fork
          run_initiator(0);
          run_initiator(1);
        join
        while (pending() != 0) @(posedge clk_i);
        repeat (20) @(posedge clk_i);  // Catch late duplicates
        $display("Simulation completed successfully");
        $finish;
      end
    join
  end

  initial begin
    repeat (200 * TOTAL_TXN) @(posedge clk_i);
    $display("Timeout, run did not finish within %0d cycles", 200 * TOTAL_TXN);
    abort_run();
  end

endmodule

// File: files.f
hw/xbar_pkg.sv
hw/xbar_addr_decode.sv
hw/xbar_demux.sv
hw/xbar_spill_reg.sv
hw/xbar_mux.sv
hw/lite_xbar.sv
verif/tb_target_mem.sv
verif/tb_lite_xbar.sv

// File: Makefile
TOP = tb_lite_xbar

all: run

build:
	verilator --binary --timing --assert -j 0 -f files.f --top-module $(TOP) -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "Simulation completed successfully" sim.log

lint:
	verilator --lint-only -Wall --timing -f files.f --top-module lite_xbar

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
